// File: source/cq_pkg.sv
package cq_pkg;

    // Widths
    localparam int CMD_W       = 128;
    localparam int BEAT_W      = 64;
    localparam int PLEN        = 56;
    localparam int PPN_W       = 44;
    localparam int IDX_W       = 32;
    localparam int VPN_W       = 52;
    localparam int DID_W       = 24;
    localparam int PID_W       = 20;
    localparam int GSCID_W     = 16;
    localparam int PSCID_W     = 20;
    localparam int OPCODE_W    = 7;
    localparam int FUNC3_W     = 3;
    localparam int ENTRY_SHIFT = 4;     // 16-byte entries
    localparam int PAGE_SHIFT  = 12;    // Queue base is page aligned

    // Opcodes and function codes
    typedef enum logic [OPCODE_W-1:0] {
        IOTINVAL = 7'd1,
        IOFENCE  = 7'd2,
        IODIR    = 7'd3,
        ATS      = 7'd4
    } cmd_opcode_e;

    typedef enum logic [FUNC3_W-1:0] {VMA = 3'd0, GVMA = 3'd1} inval_func_e;
    typedef enum logic [FUNC3_W-1:0] {INVAL_DDT = 3'd0, INVAL_PDT = 3'd1} dir_func_e;
    localparam logic [FUNC3_W-1:0] FENCE_C = 3'd0;  // Only func3 defined for IOFENCE

    // Field positions (LSB index)
    localparam int OPCODE_LSB    = 0;
    localparam int FUNC3_LSB     = 7;
    localparam int IOT_AV_BIT    = 10;
    localparam int IOT_PSCID_LSB = 12;
    localparam int IOT_PSCV_BIT  = 32;
    localparam int IOT_GV_BIT    = 33;
    localparam int IOT_GSCID_LSB = 44;
    localparam int IOT_VPN_LSB   = 74;
    localparam int DIR_PID_LSB   = 12;
    localparam int DIR_DV_BIT    = 33;
    localparam int DIR_DID_LSB   = 40;

    // Defined bits per command, anything outside is reserved
    localparam logic [CMD_W-1:0] HDR_MASK = CMD_W'({(OPCODE_W + FUNC3_W){1'b1}});
    localparam logic [CMD_W-1:0] IOTINVAL_MASK = HDR_MASK
        | (CMD_W'(1'b1) << IOT_AV_BIT)
        | (CMD_W'({PSCID_W{1'b1}}) << IOT_PSCID_LSB)
        | (CMD_W'(1'b1) << IOT_PSCV_BIT)
        | (CMD_W'(1'b1) << IOT_GV_BIT)
        | (CMD_W'({GSCID_W{1'b1}}) << IOT_GSCID_LSB)
        | (CMD_W'({VPN_W{1'b1}}) << IOT_VPN_LSB);
    localparam logic [CMD_W-1:0] IODIR_MASK = HDR_MASK
        | (CMD_W'({PID_W{1'b1}}) << DIR_PID_LSB)
        | (CMD_W'(1'b1) << DIR_DV_BIT)
        | (CMD_W'({DID_W{1'b1}}) << DIR_DID_LSB);
    localparam logic [CMD_W-1:0] IOFENCE_MASK = HDR_MASK;  // AV, WSI, PR, PW treated as reserved

endpackage

// File: source/cq_fetch.sv
`timescale 1ns/100ps

module cq_fetch (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      cq_en_i,
    input  logic [cq_pkg::PPN_W-1:0]  cq_base_ppn_i,
    input  logic [4:0]                cq_size_i,       // log2(entries) - 1
    input  logic [cq_pkg::IDX_W-1:0]  cq_tail_i,
    input  logic                      rd_gnt_i,
    input  logic                      rd_valid_i,
    input  logic                      rd_last_i,
    input  logic                      rd_err_i,
    input  logic [cq_pkg::BEAT_W-1:0] rd_data_i,
    input  logic                      buf_full_i,
    input  logic                      cmd_ill_i,
    output logic [cq_pkg::IDX_W-1:0]  cq_head_o,
    output logic                      cq_on_o,
    output logic                      busy_o,
    output logic                      cq_mf_o,
    output logic                      rd_req_o,
    output logic [cq_pkg::PLEN-1:0]   rd_addr_o,
    output logic                      push_o,
    output logic [cq_pkg::CMD_W-1:0]  push_cmd_o,
    output logic                      restart_o
);
    import cq_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, BEATS} fetch_state_e;

    fetch_state_e      state_q;
    logic              cq_en_q;          // Enable seen last cycle
    logic [IDX_W-1:0]  head_q;
    logic [IDX_W-1:0]  idx_mask;
    logic [BEAT_W-1:0] beat0_q;          // Low half of the entry
    logic [PLEN-1:0]   addr_q;
    logic              mf_q;
    logic              drop_q;           // Current read will not be pushed
    logic              start;
    logic              beat_last;

    assign idx_mask  = ~({IDX_W{1'b1}} << ({1'b0, cq_size_i} + 6'd1));
    assign busy_o    = cq_en_i != cq_en_q;     // Enable transition in progress
    assign cq_on_o   = cq_en_i | cq_en_q;
    assign restart_o = cq_en_i & ~cq_en_q;     // Rising edge of the enable

    // New entry pending and room to take it
    assign start = (state_q == IDLE) && cq_en_i && cq_en_q
                && ((cq_tail_i & idx_mask) != head_q)
                && !mf_q && !cmd_ill_i && !buf_full_i;

    assign beat_last  = (state_q == BEATS) && rd_valid_i && rd_last_i;
    assign push_o     = beat_last && !rd_err_i && !drop_q && cq_en_i;
    assign push_cmd_o = {rd_data_i, beat0_q};  // Last beat is the high half

    assign rd_req_o  = state_q == REQ;
    assign rd_addr_o = addr_q;
    assign cq_head_o = head_q;
    assign cq_mf_o   = mf_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cq_en_q <= 1'b0;
            head_q  <= '0;
            mf_q    <= 1'b0;
            drop_q  <= 1'b0;
        end else begin
            cq_en_q <= cq_en_i;
            case (state_q)
                IDLE:    if (start) state_q <= REQ;
                REQ:     if (rd_gnt_i) state_q <= BEATS;
                BEATS:   if (beat_last) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
            // Disable or an error beat poisons the read in flight
            if (start) begin
                drop_q <= 1'b0;
            end else if (state_q != IDLE && (!cq_en_i || (rd_valid_i && rd_err_i))) begin
                drop_q <= 1'b1;
            end
            if (restart_o) begin
                mf_q <= 1'b0;
            end else if (state_q == BEATS && rd_valid_i && rd_err_i) begin
                mf_q <= 1'b1;   // Stops further fetches
            end
            if (restart_o) begin
                head_q <= '0;
            end else if (push_o) begin
                head_q <= (head_q + 1'b1) & idx_mask;  // Wraps at the queue size
            end
        end
    end

    // Entry address at start and the low beat
    always_ff @(posedge clk_i) begin
        if (start) addr_q <= {cq_base_ppn_i, {PAGE_SHIFT{1'b0}}}
                           | (PLEN'(head_q) << ENTRY_SHIFT);
        if (state_q == BEATS && rd_valid_i && !rd_last_i) beat0_q <= rd_data_i;
    end

    // Memory sees a steady address until it grants
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rd_req_o && !rd_gnt_i |=> $stable(rd_addr_o));

    // Single outstanding read keeps the buffer from overflowing
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_o |-> !buf_full_i);

endmodule

// File: source/cq_cmd_buf.sv
`timescale 1ns/100ps

module cq_cmd_buf (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     push_i,
    input  logic [cq_pkg::CMD_W-1:0] push_cmd_i,
    input  logic                     pop_i,
    output logic                     full_o,
    output logic                     empty_o,
    output logic [cq_pkg::CMD_W-1:0] head_cmd_o
);
    import cq_pkg::*;

    logic [CMD_W-1:0] mem_q [2];     // Two command slots
    logic             wr_ptr_q;
    logic             rd_ptr_q;
    logic [1:0]       cnt_q;         // 0, 1 or 2 entries

    assign full_o     = cnt_q == 2'd2;
    assign empty_o    = cnt_q == 2'd0;
    assign head_cmd_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else if (flush_i) begin
            wr_ptr_q <= 1'b0;      // Drop everything held
            rd_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (push_i) wr_ptr_q <= ~wr_ptr_q;
            if (pop_i)  rd_ptr_q <= ~rd_ptr_q;
            case ({push_i, pop_i})
                2'b10:   cnt_q <= cnt_q + 2'd1;
                2'b01:   cnt_q <= cnt_q - 2'd1;
                default: cnt_q <= cnt_q;   // Both or neither keep the count
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) mem_q[wr_ptr_q] <= push_cmd_i;
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
    assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o);

endmodule

// File: source/cq_decode.sv
`timescale 1ns/100ps

module cq_decode (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       restart_i,
    input  logic                       empty_i,
    input  logic [cq_pkg::CMD_W-1:0]   head_cmd_i,
    output logic                       pop_o,
    output logic                       cmd_ill_o,
    output logic                       flush_vma_o,
    output logic                       flush_gvma_o,
    output logic                       flush_av_o,
    output logic                       flush_gv_o,
    output logic                       flush_pscv_o,
    output logic [cq_pkg::VPN_W-1:0]   flush_vpn_o,
    output logic [cq_pkg::GSCID_W-1:0] flush_gscid_o,
    output logic [cq_pkg::PSCID_W-1:0] flush_pscid_o,
    output logic                       flush_ddtc_o,
    output logic                       flush_pdtc_o,
    output logic                       flush_dv_o,
    output logic [cq_pkg::DID_W-1:0]   flush_did_o,
    output logic                       flush_pv_o,
    output logic [cq_pkg::PID_W-1:0]   flush_pid_o
);
    import cq_pkg::*;

    cmd_opcode_e        opcode;
    inval_func_e        iot_func;
    dir_func_e          dir_func;
    logic [FUNC3_W-1:0] func3;
    logic               ill_n;
    logic               vma_n, gvma_n, pscv_n;
    logic               ddtc_n, pdtc_n, pv_n;
    logic               iot_pscv, dir_dv;
    logic [PID_W-1:0]   dir_pid;

    assign opcode   = cmd_opcode_e'(head_cmd_i[OPCODE_LSB +: OPCODE_W]);
    assign func3    = head_cmd_i[FUNC3_LSB +: FUNC3_W];
    assign iot_func = inval_func_e'(func3);
    assign dir_func = dir_func_e'(func3);
    assign iot_pscv = head_cmd_i[IOT_PSCV_BIT];
    assign dir_dv   = head_cmd_i[DIR_DV_BIT];
    assign dir_pid  = head_cmd_i[DIR_PID_LSB +: PID_W];

    // Stop popping once a bad command was seen, and skip the restart cycle
    assign pop_o = !empty_i && !cmd_ill_o && !restart_i;

    always_comb begin
        ill_n  = 1'b0;
        vma_n  = 1'b0;
        gvma_n = 1'b0;
        pscv_n = 1'b0;
        ddtc_n = 1'b0;
        pdtc_n = 1'b0;
        pv_n   = 1'b0;
        case (opcode)
            IOTINVAL: begin
                if (|(head_cmd_i & ~IOTINVAL_MASK)) ill_n = 1'b1;     // Reserved bit set
                else if (iot_func == VMA) begin
                    vma_n  = 1'b1;
                    pscv_n = iot_pscv;
                end else if (iot_func == GVMA) begin
                    ill_n  = iot_pscv;        // PSCV not allowed with GVMA
                    gvma_n = !iot_pscv;
                end else ill_n = 1'b1;
            end
            IODIR: begin
                if (|(head_cmd_i & ~IODIR_MASK)) ill_n = 1'b1;
                else if (dir_func == INVAL_DDT) begin
                    ill_n  = |dir_pid;        // PID reserved for DDT
                    ddtc_n = ~|dir_pid;
                    pdtc_n = ~|dir_pid;
                end else if (dir_func == INVAL_PDT) begin
                    ill_n  = !dir_dv;         // PDT needs a valid device
                    pdtc_n = dir_dv;
                    pv_n   = dir_dv;
                end else ill_n = 1'b1;
            end
            IOFENCE: ill_n = |(head_cmd_i & ~IOFENCE_MASK) || func3 != FENCE_C;  // No-op
            default: ill_n = 1'b1;   // ATS and reserved opcodes
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmd_ill_o    <= 1'b0;
            flush_vma_o  <= 1'b0;
            flush_gvma_o <= 1'b0;
            flush_ddtc_o <= 1'b0;
            flush_pdtc_o <= 1'b0;
        end else begin
            flush_vma_o  <= pop_o & vma_n;    // One-cycle strobes
            flush_gvma_o <= pop_o & gvma_n;
            flush_ddtc_o <= pop_o & ddtc_n;
            flush_pdtc_o <= pop_o & pdtc_n;
            if (restart_i) cmd_ill_o <= 1'b0;
            else if (pop_o && ill_n) cmd_ill_o <= 1'b1;   // Held until restart
        end
    end

    // Fields ride along with the strobes
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            flush_av_o    <= (vma_n | gvma_n) & head_cmd_i[IOT_AV_BIT];
            flush_gv_o    <= (vma_n | gvma_n) & head_cmd_i[IOT_GV_BIT];
            flush_pscv_o  <= pscv_n;
            flush_vpn_o   <= head_cmd_i[IOT_VPN_LSB +: VPN_W];
            flush_gscid_o <= head_cmd_i[IOT_GSCID_LSB +: GSCID_W];
            flush_pscid_o <= head_cmd_i[IOT_PSCID_LSB +: PSCID_W];
            flush_dv_o    <= pdtc_n & dir_dv;
            flush_did_o   <= head_cmd_i[DIR_DID_LSB +: DID_W];
            flush_pv_o    <= pv_n;
            flush_pid_o   <= pv_n ? dir_pid : '0;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(flush_vma_o && flush_gvma_o));

    // An illegal command and everything after it stays unexecuted
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmd_ill_o |-> !(flush_vma_o || flush_gvma_o || flush_ddtc_o || flush_pdtc_o));

endmodule

// File: source/cq_handler.sv
`timescale 1ns/100ps

module cq_handler (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       cq_en_i,
    input  logic [cq_pkg::PPN_W-1:0]   cq_base_ppn_i,
    input  logic [4:0]                 cq_size_i,
    input  logic [cq_pkg::IDX_W-1:0]   cq_tail_i,
    input  logic                       rd_gnt_i,
    input  logic                       rd_valid_i,
    input  logic                       rd_last_i,
    input  logic                       rd_err_i,
    input  logic [cq_pkg::BEAT_W-1:0]  rd_data_i,
    output logic [cq_pkg::IDX_W-1:0]   cq_head_o,
    output logic                       cq_on_o,
    output logic                       busy_o,
    output logic                       cq_mf_o,
    output logic                       cmd_ill_o,
    output logic                       rd_req_o,
    output logic [cq_pkg::PLEN-1:0]    rd_addr_o,
    output logic                       flush_vma_o,
    output logic                       flush_gvma_o,
    output logic                       flush_av_o,
    output logic                       flush_gv_o,
    output logic                       flush_pscv_o,
    output logic [cq_pkg::VPN_W-1:0]   flush_vpn_o,
    output logic [cq_pkg::GSCID_W-1:0] flush_gscid_o,
    output logic [cq_pkg::PSCID_W-1:0] flush_pscid_o,
    output logic                       flush_ddtc_o,
    output logic                       flush_pdtc_o,
    output logic                       flush_dv_o,
    output logic [cq_pkg::DID_W-1:0]   flush_did_o,
    output logic                       flush_pv_o,
    output logic [cq_pkg::PID_W-1:0]   flush_pid_o
);
    import cq_pkg::*;

    logic             push, pop, restart;
    logic             buf_full, buf_empty;
    logic [CMD_W-1:0] push_cmd;
    logic [CMD_W-1:0] head_cmd;

    // Producer, owns head and memory fault
    cq_fetch cq_fetch_i (
        .clk_i, .rst_ni, .cq_en_i, .cq_base_ppn_i, .cq_size_i, .cq_tail_i,
        .rd_gnt_i, .rd_valid_i, .rd_last_i, .rd_err_i, .rd_data_i,
        .buf_full_i (buf_full),
        .cmd_ill_i  (cmd_ill_o),
        .cq_head_o, .cq_on_o, .busy_o, .cq_mf_o, .rd_req_o, .rd_addr_o,
        .push_o     (push),
        .push_cmd_o (push_cmd),
        .restart_o  (restart)
    );

    cq_cmd_buf cq_cmd_buf_i (
        .clk_i, .rst_ni,
        .flush_i    (restart),     // Enable edge empties the buffer
        .push_i     (push),
        .push_cmd_i (push_cmd),
        .pop_i      (pop),
        .full_o     (buf_full),
        .empty_o    (buf_empty),
        .head_cmd_o (head_cmd)
    );

    // Consumer, owns the illegal-command flag
    cq_decode cq_decode_i (
        .clk_i, .rst_ni,
        .restart_i  (restart),
        .empty_i    (buf_empty),
        .head_cmd_i (head_cmd),
        .pop_o      (pop),
        .cmd_ill_o,
        .flush_vma_o, .flush_gvma_o, .flush_av_o, .flush_gv_o, .flush_pscv_o,
        .flush_vpn_o, .flush_gscid_o, .flush_pscid_o,
        .flush_ddtc_o, .flush_pdtc_o, .flush_dv_o, .flush_did_o,
        .flush_pv_o, .flush_pid_o
    );

endmodule

// File: testbench/tb_cq_mem.sv
`timescale 1ns/100ps

module tb_cq_mem (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      rd_req_i,
    input  logic [cq_pkg::PLEN-1:0]   rd_addr_i,
    input  logic                      err_en_i,    // Inject one faulting entry
    input  logic [3:0]                err_idx_i,   // Entry that returns an error
    output logic                      rd_gnt_o,
    output logic                      rd_valid_o,
    output logic                      rd_last_o,
    output logic                      rd_err_o,
    output logic [cq_pkg::BEAT_W-1:0] rd_data_o
);
    import cq_pkg::*;

    logic [CMD_W-1:0] image [16];   // Queue image, written by the testbench
    logic [3:0]       idx;          // Entry of the read in progress
    int               seed;

    // Step whole cycles, landing just after the edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    initial begin
        seed       = 32'he945db10;
        rd_gnt_o   = 1'b0;
        rd_valid_o = 1'b0;
        rd_last_o  = 1'b0;
        rd_err_o   = 1'b0;
        rd_data_o  = '0;
        idx        = '0;
        for (int i = 0; i < 16; i++) begin
            image[i] = {8{16'(i) ^ 16'hc3a5}};     // Junk that differs per slot
        end
        forever begin
            @(posedge clk_i);
            #1;
            if (rst_ni && rd_req_i) begin
                wait_cycles(rand_below(4));         // Grant delay 0..3
                idx      = rd_addr_i[ENTRY_SHIFT +: 4];
                rd_gnt_o = 1'b1;
                wait_cycles(1);
                rd_gnt_o = 1'b0;
                for (int b = 0; b < 2; b++) begin
                    wait_cycles(rand_below(3));     // Gap 0..2 before each beat
                    rd_valid_o = 1'b1;
                    rd_last_o  = b == 1;
                    rd_err_o   = err_en_i && idx == err_idx_i && b == 0;
                    rd_data_o  = image[idx][b*BEAT_W +: BEAT_W];   // Low half first
                    wait_cycles(1);
                    rd_valid_o = 1'b0;
                    rd_last_o  = 1'b0;
                    rd_err_o   = 1'b0;
                end
            end
        end
    end

endmodule

// File: testbench/tb_cq_handler.sv
`timescale 1ns/100ps

module tb_cq_handler;
    import cq_pkg::*;

    localparam int EXP_W      = 142;    // Strobes and fields packed for compare
    localparam int MAX_CYCLES = 2000;
    localparam logic [PPN_W-1:0] BASE_PPN = 44'h123_4567_89ab;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 cq_en_i;
    logic [PPN_W-1:0]     cq_base_ppn_i;
    logic [4:0]           cq_size_i;
    logic [IDX_W-1:0]     cq_tail_i;
    logic                 rd_gnt_i, rd_valid_i, rd_last_i, rd_err_i;
    logic [BEAT_W-1:0]    rd_data_i;
    logic [IDX_W-1:0]     cq_head_o;
    logic                 cq_on_o, busy_o, cq_mf_o, cmd_ill_o, rd_req_o;
    logic [PLEN-1:0]      rd_addr_o;
    logic                 flush_vma_o, flush_gvma_o, flush_av_o, flush_gv_o, flush_pscv_o;
    logic [VPN_W-1:0]     flush_vpn_o;
    logic [GSCID_W-1:0]   flush_gscid_o;
    logic [PSCID_W-1:0]   flush_pscid_o;
    logic                 flush_ddtc_o, flush_pdtc_o, flush_dv_o, flush_pv_o;
    logic [DID_W-1:0]     flush_did_o;
    logic [PID_W-1:0]     flush_pid_o;

    logic                 err_en;
    logic [3:0]           err_idx;
    logic [EXP_W-1:0]     exp_q [$];   // Expected results, in command order
    logic [EXP_W-1:0]     obs;
    logic                 iot, dir;
    logic                 ill_seen = 1'b0;
    logic [IDX_W-1:0]     rd_idx = '0; // Entry the next read should fetch
    logic [CMD_W-1:0]     bad;
    int                   seed = 32'he945db10;
    int                   err_cnt = 0;
    int                   check_cnt = 0;
    int                   test_base = 0;
    int                   cycles = 0;

    cq_handler cq_handler_i (.*);

    tb_cq_mem cq_mem_i (
        .clk_i, .rst_ni,
        .rd_req_i   (rd_req_o),
        .rd_addr_i  (rd_addr_o),
        .err_en_i   (err_en),
        .err_idx_i  (err_idx),
        .rd_gnt_o   (rd_gnt_i),
        .rd_valid_o (rd_valid_i),
        .rd_last_o  (rd_last_i),
        .rd_err_o   (rd_err_i),
        .rd_data_o  (rd_data_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_value(input logic [EXP_W-1:0] got, input logic [EXP_W-1:0] exp,
                               input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Expected {ill, vma, gvma, av, gv, pscv, vpn, gscid, pscid, ddtc, pdtc, dv, did, pv, pid}
    function automatic logic [EXP_W-1:0] expect_flush(input logic [CMD_W-1:0] c);
        logic       ill;
        logic       vma, gvma, ddtc, pdtc, pv;
        logic [2:0] f3;
        ill  = 1'b0;
        vma  = 1'b0;
        gvma = 1'b0;
        ddtc = 1'b0;
        pdtc = 1'b0;
        pv   = 1'b0;
        f3   = c[9:7];
        case (c[6:0])
            7'd1: begin    // IOTINVAL
                if (c[11] || |c[43:34] || |c[73:60] || |c[127:126] || f3 > 3'd1
                    || (f3 == 3'd1 && c[32])) begin
                    ill = 1'b1;
                end else begin
                    vma  = f3 == 3'd0;
                    gvma = f3 == 3'd1;
                end
            end
            7'd3: begin    // IODIR
                if (|c[11:10] || c[32] || |c[39:34] || |c[127:64] || f3 > 3'd1
                    || (f3 == 3'd0 && |c[31:12]) || (f3 == 3'd1 && !c[33])) begin
                    ill = 1'b1;
                end else begin
                    ddtc = f3 == 3'd0;
                    pdtc = 1'b1;            // Both functions drop PDT entries
                    pv   = f3 == 3'd1;
                end
            end
            7'd2:    ill = |c[127:7];       // IOFENCE.C is a no-op
            default: ill = 1'b1;            // ATS and reserved opcodes
        endcase
        if (ill) return {1'b1, {(EXP_W-1){1'b0}}};
        return {1'b0, vma, gvma, (vma | gvma) & c[10], (vma | gvma) & c[33], vma & c[32],
                (vma | gvma) ? {c[125:74], c[59:44], c[31:12]} : 88'h0,
                ddtc, pdtc, pdtc & c[33], pdtc ? c[63:40] : 24'h0,
                pv, pv ? c[31:12] : 20'h0};
    endfunction

    function automatic void queue_expected(input logic [CMD_W-1:0] cmd);
        logic [EXP_W-1:0] r;
        r = expect_flush(cmd);
        if (r != '0) exp_q.push_back(r);    // No-ops leave no trace
    endfunction

    function automatic logic [CMD_W-1:0] iotinval_cmd(input logic [2:0] f3, input logic av,
                                                       input logic gv, input logic pscv);
        logic [CMD_W-1:0] c;
        c = '0;
        c[OPCODE_LSB +: OPCODE_W]   = IOTINVAL;
        c[FUNC3_LSB +: FUNC3_W]     = f3;
        c[IOT_AV_BIT]               = av;
        c[IOT_PSCV_BIT]             = pscv;
        c[IOT_GV_BIT]               = gv;
        c[IOT_PSCID_LSB +: PSCID_W] = PSCID_W'($random(seed));
        c[IOT_GSCID_LSB +: GSCID_W] = GSCID_W'($random(seed));
        c[IOT_VPN_LSB +: VPN_W]     = VPN_W'({$random(seed), $random(seed)});
        return c;
    endfunction

    function automatic logic [CMD_W-1:0] iodir_cmd(input logic [2:0] f3, input logic dv);
        logic [CMD_W-1:0] c;
        c = '0;
        c[OPCODE_LSB +: OPCODE_W] = IODIR;
        c[FUNC3_LSB +: FUNC3_W]   = f3;
        c[DIR_DV_BIT]             = dv;
        c[DIR_DID_LSB +: DID_W]   = DID_W'($random(seed));
        if (f3 == INVAL_PDT) c[DIR_PID_LSB +: PID_W] = PID_W'($random(seed));
        return c;
    endfunction

    function automatic logic [CMD_W-1:0] random_legal(input int kind);
        logic [31:0] r;
        r = $random(seed);
        case (kind % 4)
            0:       return iotinval_cmd(VMA, r[0], r[1], r[2]);
            1:       return iotinval_cmd(GVMA, r[0], r[1], 1'b0);
            2:       return iodir_cmd(INVAL_DDT, r[0]);
            default: return iodir_cmd(INVAL_PDT, 1'b1);
        endcase
    endfunction

    task automatic next_sample();
        @(negedge clk_i);
        #1;
    endtask

    task automatic move_tail(input logic [IDX_W-1:0] tail);
        @(posedge clk_i);
        #1;
        cq_tail_i = tail;
    endtask

    // Busy for exactly one cycle on either edge of the enable
    task automatic set_enable(input logic en);
        @(posedge clk_i);
        #1;
        cq_en_i = en;
        @(negedge clk_i);
        check_value(EXP_W'({busy_o, cq_on_o}), EXP_W'(2'b11), "busy and on at enable edge");
        @(negedge clk_i);
        check_value(EXP_W'({busy_o, cq_on_o}), EXP_W'({1'b0, en}), "busy and on after edge");
    endtask

    task automatic restart_queue(input logic [4:0] size);
        if (cq_en_i) set_enable(1'b0);
        @(posedge clk_i);
        #1;
        cq_size_i = size;
        cq_tail_i = '0;
        err_en    = 1'b0;
        rd_idx    = '0;
        set_enable(1'b1);
        check_value(EXP_W'({cq_head_o, cq_mf_o, cmd_ill_o}), '0, "head and flags after restart");
    endtask

    task automatic run_stream(input int first, input int n, input logic [IDX_W-1:0] tail);
        logic [IDX_W-1:0] mask;
        logic [CMD_W-1:0] cmd;
        mask = (IDX_W'(2) << cq_size_i) - IDX_W'(1);
        for (int i = 0; i < n; i++) begin
            cmd = random_legal(i);
            cq_mem_i.image[(first + i) & int'(mask)] = cmd;
            queue_expected(cmd);
        end
        move_tail(tail);
        while (cq_head_o != (tail & mask) || exp_q.size() != 0) next_sample();
        repeat (10) next_sample();               // Room for a stray strobe
        check_value(EXP_W'(cq_head_o), EXP_W'(tail & mask), "head equals masked tail");
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d %s: %0d errors", num, name, err_cnt - test_base);
        test_base = err_cnt;
    endtask

    // Each strobe or new illegal flag consumes the next expected result
    always @(negedge clk_i) begin
        if (rst_ni) begin
            iot = flush_vma_o | flush_gvma_o;
            dir = flush_ddtc_o | flush_pdtc_o;
            obs = {cmd_ill_o & !ill_seen, flush_vma_o, flush_gvma_o,
                   iot & flush_av_o, iot & flush_gv_o, iot & flush_pscv_o,
                   iot ? {flush_vpn_o, flush_gscid_o, flush_pscid_o} : 88'h0,
                   flush_ddtc_o, flush_pdtc_o, dir & flush_dv_o, dir ? flush_did_o : 24'h0,
                   dir & flush_pv_o, dir ? flush_pid_o : 20'h0};
            if (obs != '0) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("Unexpected flush or illegal flag at %0t ns with nothing pending",
                             $time);
                end else begin
                    check_value(obs, exp_q.pop_front(), "command result");
                end
            end
            // Reads walk the ring in order from entry 0 after each restart
            if (rd_req_o) begin
                check_value(EXP_W'(rd_addr_o),
                            EXP_W'({BASE_PPN, 12'h000} | (PLEN'(rd_idx) << 4)),
                            "read address");
                if (rd_gnt_i) begin
                    rd_idx = (rd_idx + IDX_W'(1)) & ((IDX_W'(2) << cq_size_i) - IDX_W'(1));
                end
            end
        end
        ill_seen = cmd_ill_o;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles without finishing", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        cq_en_i       = 1'b0;
        cq_base_ppn_i = BASE_PPN;
        cq_size_i     = 5'd3;
        cq_tail_i     = '0;
        err_en        = 1'b0;
        err_idx       = 4'd0;
        rst_ni        = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        next_sample();
        check_value(EXP_W'({rd_req_o, flush_vma_o, flush_gvma_o, flush_ddtc_o, flush_pdtc_o,
                    cq_mf_o, cmd_ill_o, busy_o, cq_on_o, cq_head_o}), '0, "reset state");

        restart_queue(5'd3);                     // 16 entries
        run_stream(0, 8, 32'd8);
        report_test(1, "legal stream");

        restart_queue(5'd1);                     // 4 entries
        run_stream(0, 3, 32'd3);
        run_stream(3, 3, 32'd6);                 // Tail past the end wraps the head through 0
        report_test(2, "wrap-around");

        for (int k = 0; k < 3; k++) begin
            restart_queue(5'd3);
            case (k)
                0:       bad = random_legal(0) | (CMD_W'(1) << 11);   // Reserved bit
                1:       bad = iotinval_cmd(GVMA, 1'b0, 1'b0, 1'b1);
                default: bad = CMD_W'(ATS);
            endcase
            cq_mem_i.image[0] = random_legal(1);
            cq_mem_i.image[1] = bad;
            cq_mem_i.image[2] = random_legal(2);
            cq_mem_i.image[3] = random_legal(3);
            queue_expected(cq_mem_i.image[0]);
            queue_expected(bad);
            move_tail(32'd4);
            while (!(cmd_ill_o && exp_q.size() == 0)) next_sample();
            repeat (30) next_sample();
            check_value(EXP_W'(cq_head_o <= 32'd3), EXP_W'(1), "head stops near illegal entry");
            check_value(EXP_W'(cmd_ill_o), EXP_W'(1), "illegal flag held");
        end
        report_test(3, "illegal command");

        restart_queue(5'd3);
        @(posedge clk_i);
        #1;
        err_en  = 1'b1;
        err_idx = 4'd2;
        for (int i = 0; i < 4; i++) begin
            cq_mem_i.image[i] = random_legal(i);
            if (i < 2) queue_expected(cq_mem_i.image[i]);   // Entries before the fault
        end
        move_tail(32'd4);
        while (!(cq_mf_o && exp_q.size() == 0)) next_sample();
        repeat (30) next_sample();
        check_value(EXP_W'({cq_head_o, cq_mf_o}), EXP_W'({32'd2, 1'b1}), "head held at fault");
        report_test(4, "memory fault");

        restart_queue(5'd3);                     // Clears both flags and the head
        run_stream(0, 8, 32'd8);
        report_test(5, "restart");

        $display("Tests: 5, checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
source/cq_pkg.sv
source/cq_fetch.sv
source/cq_cmd_buf.sv
source/cq_decode.sv
source/cq_handler.sv
testbench/tb_cq_mem.sv
testbench/tb_cq_handler.sv

// File: Makefile
TOP = tb_cq_handler

.PHONY: run build lint clean

run: build
	./obj_dir/sim | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

build:
	verilator --binary --timing --assert -sv -f compile.f --top-module $(TOP) \
		-Mdir obj_dir -o sim

lint:
	verilator --lint-only --timing -sv -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
